// ==== logic/cp0_pkg.sv ====
package cp0_pkg;

    // data path
    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;     // register data and pc values
    typedef logic [4:0]      reg_num_t;  // cp0 register number
    typedef logic [4:0]      exc_code_t; // cause ExcCode field
    typedef logic [7:0]      irq_t;      // interrupt lines and masks

    // coprocessor register numbers, select 0 only
    localparam reg_num_t status_reg_num = 5'd12;
    localparam reg_num_t cause_reg_num  = 5'd13;
    localparam reg_num_t epc_reg_num    = 5'd14;

    // ExcCode values
    localparam exc_code_t exc_int = 5'h00; // external interrupt
    localparam exc_code_t exc_ov  = 5'h0c; // arithmetic overflow
    localparam exc_code_t exc_ri  = 5'h0a; // reserved instruction
    localparam exc_code_t exc_sys = 5'h08; // syscall
    localparam exc_code_t exc_bp  = 5'h09; // break

    // status bit positions
    localparam int ie_bit  = 0;
    localparam int exl_bit = 1;

    // BEV-like bit 22 and bit 2 set out of reset, IE and EXL clear
    localparam logic [31:0] status_reset = 32'h00400004;

endpackage

// ==== logic/irq_sync.sv ====
`timescale 1ns/1ps

module irq_sync #(
    parameter int unsigned sync_stages = 2
) (
    input  logic          clock,
    input  logic          arst_n,
    input  cp0_pkg::irq_t irq,
    output cp0_pkg::irq_t irq_pending
);

    // one row per stage, row 0 samples the raw lines
    cp0_pkg::irq_t [sync_stages-1:0] sync_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[sync_stages-2:0], irq}; // shift toward the last stage
        end
    end

    assign irq_pending = sync_q[sync_stages-1];

    // a single flop gives no metastability protection
    a_min_stages: assert property (@(posedge clock) sync_stages >= 2)
        else $error("irq_sync: sync_stages must be at least 2");

endmodule

// ==== logic/exc_detect.sv ====
`timescale 1ns/1ps

module exc_detect (
    input  logic               overflow,
    input  logic               reserved_inst,
    input  logic               syscall,
    input  logic               break_,
    input  logic               exc_level,
    output logic               exc_valid,
    output cp0_pkg::exc_code_t exc_code
);

    logic any_flag;

    assign any_flag = overflow | reserved_inst | syscall | break_;

    // nested exceptions are not taken while the handler runs
    assign exc_valid = !exc_level && any_flag;

    // fixed priority, overflow highest
    always_comb begin
        exc_code = cp0_pkg::exc_int; // idle value
        if (exc_valid) begin
            if (overflow) begin
                exc_code = cp0_pkg::exc_ov;
            end else if (reserved_inst) begin
                exc_code = cp0_pkg::exc_ri;
            end else if (syscall) begin
                exc_code = cp0_pkg::exc_sys;
            end else begin
                exc_code = cp0_pkg::exc_bp; // only break_ left
            end
        end
    end

endmodule

// ==== logic/cp0.sv ====
`timescale 1ns/1ps

module cp0 #(
    parameter cp0_pkg::word_t handler_pc = 64'h0000_0000_8000_0180
) (
    input  logic               clock,
    input  logic               arst_n,
    input  cp0_pkg::reg_num_t  regnum,
    input  cp0_pkg::word_t     wr_data,
    input  logic               mtc0,
    input  logic               eret,
    input  cp0_pkg::word_t     next_pc,
    input  cp0_pkg::irq_t      irq_pending,
    input  logic               exc_valid,
    input  cp0_pkg::exc_code_t exc_code,
    output cp0_pkg::word_t     rd_data,
    output cp0_pkg::word_t     epc,
    output logic               exc_level,
    output logic               redirect,
    output cp0_pkg::word_t     redirect_pc
);

    logic [31:0]        status_q;
    logic [31:0]        cause;
    cp0_pkg::exc_code_t code_q;
    cp0_pkg::exc_code_t trap_code;
    cp0_pkg::word_t     epc_q;
    cp0_pkg::word_t     redirect_pc_q;
    logic               redirect_q;
    logic               ie;
    logic               exl;
    logic               int_trap;
    logic               take_trap;
    logic               wr_status;
    logic               wr_epc;

    assign ie  = status_q[cp0_pkg::ie_bit];
    assign exl = status_q[cp0_pkg::exl_bit];

    // cause is assembled, only the code field is stored
    assign cause = {16'b0, irq_pending, 1'b0, code_q, 2'b0};

    assign wr_status = mtc0 && (regnum == cp0_pkg::status_reg_num);
    assign wr_epc    = mtc0 && (regnum == cp0_pkg::epc_reg_num);

    // interrupt needs global enable, no active handler and an unmasked line
    assign int_trap  = ie && !exl && |(irq_pending & status_q[15:8]);
    assign take_trap = exc_valid || int_trap;

    // a synchronous exception wins over a pending interrupt
    assign trap_code = exc_valid ? exc_code : cp0_pkg::exc_int;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            status_q <= cp0_pkg::status_reset;
        end else if (take_trap) begin
            status_q[cp0_pkg::exl_bit] <= 1'b1; // enter handler, write dropped
        end else if (eret) begin
            status_q[cp0_pkg::exl_bit] <= 1'b0;
        end else if (wr_status) begin
            status_q <= wr_data[31:0];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            epc_q  <= '0;
            code_q <= cp0_pkg::exc_int;
        end else if (take_trap) begin
            epc_q  <= next_pc; // resume point
            code_q <= trap_code;
        end else if (wr_epc) begin
            epc_q <= wr_data;
        end
    end

    // one-cycle redirect pulse toward fetch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= take_trap || eret;
        end
    end

    always_ff @(posedge clock) begin
        if (take_trap) begin
            redirect_pc_q <= handler_pc;
        end else if (eret) begin
            redirect_pc_q <= epc_q; // epc before any update this edge
        end
    end

    always_comb begin
        case (regnum)
            cp0_pkg::status_reg_num: rd_data = {32'b0, status_q};
            cp0_pkg::cause_reg_num:  rd_data = {32'b0, cause};
            cp0_pkg::epc_reg_num:    rd_data = epc_q;
            default:                 rd_data = '0;
        endcase
    end

    assign epc         = epc_q;
    assign exc_level   = exl;
    assign redirect    = redirect_q;
    assign redirect_pc = redirect_pc_q;

    // pipeline only issues eret from inside a handler
    a_eret_in_handler: assert property (
        @(posedge clock) disable iff (!arst_n) eret |-> exl
    ) else $error("cp0: eret while EXL is clear");

    // fetch must see a single pulse per trap or return
    a_redirect_pulse: assert property (
        @(posedge clock) disable iff (!arst_n) redirect |=> !redirect
    ) else $error("cp0: redirect held for two cycles");

endmodule

// ==== logic/cp0_unit.sv ====
`timescale 1ns/1ps

module cp0_unit #(
    parameter cp0_pkg::word_t handler_pc  = 64'h0000_0000_8000_0180,
    parameter int unsigned    sync_stages = 2
) (
    input  logic              clock,
    input  logic              arst_n,
    input  cp0_pkg::irq_t     irq,
    input  logic              overflow,
    input  logic              reserved_inst,
    input  logic              syscall,
    input  logic              break_,
    input  cp0_pkg::reg_num_t regnum,
    input  cp0_pkg::word_t    wr_data,
    input  logic              mtc0,
    input  logic              eret,
    input  cp0_pkg::word_t    next_pc,
    output cp0_pkg::word_t    rd_data,
    output cp0_pkg::word_t    epc,
    output logic              redirect,
    output cp0_pkg::word_t    redirect_pc
);

    cp0_pkg::irq_t      irq_pending;
    cp0_pkg::exc_code_t exc_code;
    logic               exc_valid;
    logic               exc_level; // EXL fed back to the ranking

    irq_sync #(
        .sync_stages (sync_stages)
    ) i_irq_sync (
        .clock       (clock),
        .arst_n      (arst_n),
        .irq         (irq),
        .irq_pending (irq_pending)
    );

    exc_detect i_exc_detect (
        .overflow      (overflow),
        .reserved_inst (reserved_inst),
        .syscall       (syscall),
        .break_        (break_),
        .exc_level     (exc_level),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code)
    );

    cp0 #(
        .handler_pc (handler_pc)
    ) i_cp0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .regnum      (regnum),
        .wr_data     (wr_data),
        .mtc0        (mtc0),
        .eret        (eret),
        .next_pc     (next_pc),
        .irq_pending (irq_pending),
        .exc_valid   (exc_valid),
        .exc_code    (exc_code),
        .rd_data     (rd_data),
        .epc         (epc),
        .exc_level   (exc_level),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

// ==== bench/cp0_model.svh ====
`ifndef cp0_model_svh
`define cp0_model_svh

// flags packed as {overflow, reserved_inst, syscall, break_}
function automatic cp0_pkg::exc_code_t rank_code(logic [3:0] flags);
    return flags[3] ? cp0_pkg::exc_ov  :
           flags[2] ? cp0_pkg::exc_ri  :
           flags[1] ? cp0_pkg::exc_sys :
           flags[0] ? cp0_pkg::exc_bp  : cp0_pkg::exc_int;
endfunction

// exceptions only count outside a handler
function automatic logic exc_taken(logic [3:0] flags, logic [31:0] status);
    return (flags != 4'b0) && !status[1];
endfunction

function automatic logic int_taken(logic [31:0] status, cp0_pkg::irq_t pend);
    return status[0] && !status[1] && ((pend & status[15:8]) != 8'b0);
endfunction

function automatic cp0_pkg::word_t read_reg(cp0_pkg::reg_num_t r, logic [31:0] status,
                                            cp0_pkg::exc_code_t code, cp0_pkg::irq_t pend,
                                            cp0_pkg::word_t epc);
    case (r)
        cp0_pkg::status_reg_num: return {32'b0, status};
        cp0_pkg::cause_reg_num:  return {48'b0, pend, 1'b0, code, 2'b0};
        cp0_pkg::epc_reg_num:    return epc;
        default:                 return '0;
    endcase
endfunction

// a trap beats a software write
function automatic logic [31:0] status_next(logic [31:0] status, logic trap, logic ret,
                                            logic wr, logic [31:0] data);
    logic [31:0] s;
    s = wr ? data : status;
    if (trap) begin
        s = status | 32'h2;
    end else if (ret) begin
        s = status & ~32'h2;
    end
    return s;
endfunction

function automatic cp0_pkg::word_t epc_next(cp0_pkg::word_t epc, logic trap, logic wr,
                                            cp0_pkg::word_t data, cp0_pkg::word_t pc);
    return trap ? pc : (wr ? data : epc);
endfunction

`endif

// ==== bench/tb_cp0_unit.sv ====
`timescale 1ns/1ps

module tb_cp0_unit;

    `include "cp0_model.svh"

    localparam cp0_pkg::word_t handler_pc  = 64'h80000180;
    localparam int             sync_stages = 2;
    localparam int             test_cycles = 6 + 33 + 40 + 10 + 35 + 122; // cycles of each test

    logic               clock;
    logic               arst_n;
    cp0_pkg::irq_t      irq;
    logic [3:0]         flags; // {overflow, reserved_inst, syscall, break_}
    cp0_pkg::reg_num_t  regnum;
    cp0_pkg::word_t     wr_data;
    logic               mtc0;
    logic               eret;
    cp0_pkg::word_t     next_pc;
    cp0_pkg::word_t     rd_data;
    cp0_pkg::word_t     epc;
    logic               redirect;
    cp0_pkg::word_t     redirect_pc;

    // reference state advanced once per clock by step()
    logic [31:0]        m_status;
    cp0_pkg::exc_code_t m_code;
    cp0_pkg::word_t     m_epc;
    cp0_pkg::irq_t      m_sync [sync_stages];
    logic               m_redirect;
    cp0_pkg::word_t     m_redirect_pc;

    logic [31:0]        lfsr = 32'h7b34;
    string              test_name = "reset";
    int                 test_errors = 0;
    int                 errors = 0;
    int                 tests_run = 0;

    cp0_unit #(
        .handler_pc  (handler_pc),
        .sync_stages (sync_stages)
    ) i_cp0_unit (
        .clock         (clock),
        .arst_n        (arst_n),
        .irq           (irq),
        .overflow      (flags[3]),
        .reserved_inst (flags[2]),
        .syscall       (flags[1]),
        .break_        (flags[0]),
        .regnum        (regnum),
        .wr_data       (wr_data),
        .mtc0          (mtc0),
        .eret          (eret),
        .next_pc       (next_pc),
        .rd_data       (rd_data),
        .epc           (epc),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        #((5 + test_cycles + 100) * 8);
        $display("watchdog: the test sequence did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic cp0_pkg::word_t lfsr_bits(int n);
        cp0_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic cp0_pkg::reg_num_t pick_reg();
        logic [1:0] sel;
        sel = 2'(lfsr_bits(2));
        return (sel == 2'd0) ? cp0_pkg::cause_reg_num :
               sel[0] ? cp0_pkg::epc_reg_num : cp0_pkg::status_reg_num;
    endfunction

    function automatic cp0_pkg::word_t model_read(cp0_pkg::reg_num_t r);
        return read_reg(r, m_status, m_code, m_sync[sync_stages-1], m_epc);
    endfunction

    task automatic check(string what, cp0_pkg::word_t expected, cp0_pkg::word_t actual);
        if (expected !== actual) begin
            $display("** Error %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        $display("test %-12s %s, %0d errors", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
        tests_run++;
        errors += test_errors;
        test_errors = 0;
    endtask

    // predict the edge from the inputs now held, then move to 1 ns past it
    task automatic step();
        logic [31:0]        status_n;
        cp0_pkg::word_t     epc_n;
        cp0_pkg::exc_code_t code_n;
        cp0_pkg::irq_t      irq_now;
        logic               exc;
        logic               trap;
        logic               ret;
        exc      = exc_taken(flags, m_status);
        trap     = exc || int_taken(m_status, m_sync[sync_stages-1]);
        ret      = eret;
        status_n = status_next(m_status, trap, ret,
                               mtc0 && (regnum == cp0_pkg::status_reg_num), wr_data[31:0]);
        epc_n    = epc_next(m_epc, trap, mtc0 && (regnum == cp0_pkg::epc_reg_num),
                            wr_data, next_pc);
        code_n   = trap ? (exc ? rank_code(flags) : cp0_pkg::exc_int) : m_code;
        irq_now  = irq;
        @(posedge clock);
        m_redirect = trap || ret;
        if (trap) begin
            m_redirect_pc = handler_pc;
        end else if (ret) begin
            m_redirect_pc = m_epc; // return target is the old epc
        end
        m_status = status_n;
        m_epc    = epc_n;
        m_code   = code_n;
        for (int i = sync_stages - 1; i > 0; i--) begin
            m_sync[i] = m_sync[i-1];
        end
        m_sync[0] = irq_now;
        #1;
    endtask

    task automatic write_reg(cp0_pkg::reg_num_t r, cp0_pkg::word_t data);
        regnum  = r;
        wr_data = data;
        mtc0    = 1'b1;
        step();
        mtc0    = 1'b0;
    endtask

    task automatic read_check(string what, cp0_pkg::reg_num_t r, cp0_pkg::word_t expected);
        regnum = r;
        #1;
        check(what, expected, rd_data);
        step();
    endtask

    task automatic quiet_cycles(int n);
        repeat (n) begin
            step();
            check("no redirect", '0, cp0_pkg::word_t'(redirect));
        end
    endtask

    // scoreboard sampled mid-cycle
    always @(negedge clock) begin
        if (arst_n) begin
            check("redirect", cp0_pkg::word_t'(m_redirect), cp0_pkg::word_t'(redirect));
            if (m_redirect) begin
                check("redirect_pc", m_redirect_pc, redirect_pc);
            end
            check("rd_data", model_read(regnum), rd_data);
            check("epc port", m_epc, epc);
        end
    end

    initial begin
        cp0_pkg::word_t    pc;
        cp0_pkg::irq_t     line;
        cp0_pkg::reg_num_t r;
        logic [3:0]        f;
        int                cycles;
        irq        = '0;
        flags      = '0;
        regnum     = '0;
        wr_data    = '0;
        mtc0       = 1'b0;
        eret       = 1'b0;
        next_pc    = '0;
        arst_n     = 1'b0;
        m_status   = cp0_pkg::status_reset;
        m_code     = cp0_pkg::exc_int;
        m_epc      = '0;
        m_redirect = 1'b0;
        foreach (m_sync[i]) m_sync[i] = '0;
        repeat (5) @(posedge clock);
        #1;
        arst_n = 1'b1;

        check("redirect", '0, cp0_pkg::word_t'(redirect));
        read_check("status", cp0_pkg::status_reg_num, {32'b0, cp0_pkg::status_reset});
        read_check("cause", cp0_pkg::cause_reg_num, '0);
        read_check("epc", cp0_pkg::epc_reg_num, '0);
        read_check("unmapped", 5'd3, '0);
        finish_test();

        test_name = "move_to";
        repeat (16) begin
            r = pick_reg();
            write_reg(r, lfsr_bits(64));
            read_check("readback", r, model_read(r));
        end
        finish_test();

        test_name = "exception";
        write_reg(cp0_pkg::status_reg_num, '0);
        repeat (12) begin
            f = 4'(lfsr_bits(4));
            if (f == 4'b0) f = 4'b0001;
            pc      = lfsr_bits(64);
            flags   = f;
            next_pc = pc;
            step();
            flags = '0;
            check("redirect", 64'd1, cp0_pkg::word_t'(redirect));
            check("redirect_pc", handler_pc, redirect_pc);
            check("epc", pc, epc);
            read_check("cause code", cp0_pkg::cause_reg_num, {57'b0, rank_code(f), 2'b0});
            write_reg(cp0_pkg::status_reg_num, '0); // leave the handler
        end
        finish_test();

        test_name = "exl_eret";
        pc      = lfsr_bits(64);
        flags   = 4'b0010;
        next_pc = pc;
        step(); // enters the handler
        repeat (4) begin
            flags   = 4'(lfsr_bits(4)) | 4'b1000;
            next_pc = lfsr_bits(64);
            step();
            check("masked redirect", '0, cp0_pkg::word_t'(redirect));
        end
        flags = '0;
        eret  = 1'b1;
        step();
        eret  = 1'b0;
        check("eret redirect", 64'd1, cp0_pkg::word_t'(redirect));
        check("eret target", pc, redirect_pc);
        read_check("status", cp0_pkg::status_reg_num, model_read(cp0_pkg::status_reg_num));
        finish_test();

        test_name = "interrupt";
        line = 8'b1 << 3'(lfsr_bits(3));
        write_reg(cp0_pkg::status_reg_num, {48'b0, line, 8'h01});
        irq    = line;
        cycles = 0;
        while (!redirect && cycles < 10) begin
            step();
            cycles++;
        end
        check("latency", cp0_pkg::word_t'(sync_stages + 1), cp0_pkg::word_t'(cycles));
        check("redirect_pc", handler_pc, redirect_pc);
        read_check("cause", cp0_pkg::cause_reg_num, {48'b0, line, 1'b0, cp0_pkg::exc_int, 2'b0});
        irq = '0;
        repeat (sync_stages) step();
        write_reg(cp0_pkg::status_reg_num, {48'b0, ~line, 8'h01}); // line masked
        irq = line;
        quiet_cycles(10);
        write_reg(cp0_pkg::status_reg_num, {48'b0, line, 8'h00}); // IE clear
        quiet_cycles(10);
        irq = '0;
        repeat (sync_stages) step();
        finish_test();

        test_name = "random_mix";
        repeat (40) begin
            case (2'(lfsr_bits(2)))
                2'd0: begin
                    regnum  = pick_reg();
                    wr_data = lfsr_bits(64);
                    mtc0    = 1'b1;
                end
                2'd1: begin
                    flags   = 4'(lfsr_bits(4));
                    next_pc = lfsr_bits(64);
                end
                2'd2: eret = m_status[1]; // only from inside a handler
                default: regnum = 5'(lfsr_bits(5));
            endcase
            step();
            mtc0  = 1'b0;
            flags = '0;
            eret  = 1'b0;
            check("epc", m_epc, epc);
            // the two reads also keep redirect pulses apart
            read_check("status", cp0_pkg::status_reg_num,
                       model_read(cp0_pkg::status_reg_num));
            read_check("cause", cp0_pkg::cause_reg_num, model_read(cp0_pkg::cause_reg_num));
        end
        finish_test();

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+bench
logic/cp0_pkg.sv
logic/irq_sync.sv
logic/exc_detect.sv
logic/cp0.sv
logic/cp0_unit.sv
bench/tb_cp0_unit.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module tb_cp0_unit -Mdir obj_dir -o sim_cp0
	./obj_dir/sim_cp0 | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module tb_cp0_unit
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module cp0_unit

clean:
	rm -rf obj_dir $(LOG)
